//--- sources.f
src/tlb_pkg.sv
src/va_bank.sv
src/search_ctrl.sv
src/hit_merge.sv
src/pa_lookup.sv
src/l2_tlb.sv
tb/tb_l2_tlb.sv

//--- src/hit_merge.sv
////////////////////////////////////////////////////////////
// Hit merge across the VA banks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hit_merge #(
   parameter int N_SETS    = tlb_pkg::DEF_N_SETS,
   parameter int N_OFFSETS = tlb_pkg::DEF_N_OFFSETS,
   parameter int N_BANKS   = tlb_pkg::DEF_N_BANKS
) (
   input  logic [N_BANKS-1:0]                                         bank_hit_i,
   input  logic [N_BANKS-1:0]                                         bank_prot_i,
   input  logic [N_BANKS-1:0]                                         bank_multi_i,
   input  logic [N_BANKS-1:0]                                         bank_coh_i,
   input  logic [N_BANKS-1:0][$clog2(N_SETS)+$clog2(N_OFFSETS):0]     bank_entry_i,
   output logic                                                       hit_any_o,
   output logic                                                       prot_any_o,
   output logic                                                       multi_any_o,
   output logic                                                       coh_sel_o,
   output logic [$clog2(N_SETS)+$clog2(N_OFFSETS)+$clog2(N_BANKS):0] pa_index_o
);

   localparam int IDX_W = $clog2(N_SETS) + 1 + $clog2(N_OFFSETS) + $clog2(N_BANKS);

   assign prot_any_o = |bank_prot_i;

   // Scan from the top so the lowest hitting bank is the last one kept
   always_comb begin
      hit_any_o   = 1'b0;
      multi_any_o = 1'b0;
      coh_sel_o   = 1'b0;
      pa_index_o  = '0;
      for (int b = N_BANKS - 1; b >= 0; b--) begin
         if (bank_hit_i[b]) begin
            multi_any_o = multi_any_o | hit_any_o | bank_multi_i[b];   // Second hit is multi
            hit_any_o   = 1'b1;
            coh_sel_o   = bank_coh_i[b];
            pa_index_o  = IDX_W'(bank_entry_i[b] * N_BANKS + b);
         end
      end
   end

endmodule

`default_nettype wire

//--- src/l2_tlb.sv
////////////////////////////////////////////////////////////
// L2 TLB top level
// Search control, VA banks, hit merge and PA lookup
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l2_tlb #(
   parameter int N_SETS    = tlb_pkg::DEF_N_SETS,
   parameter int N_OFFSETS = tlb_pkg::DEF_N_OFFSETS,
   parameter int N_BANKS   = tlb_pkg::DEF_N_BANKS
) (
   input  logic                               clk_i,
   input  logic                               rst_ni,
   input  logic                               we_i,
   input  logic [tlb_pkg::CFG_ADDR_WIDTH-1:0] waddr_i,
   input  logic [tlb_pkg::CFG_DATA_WIDTH-1:0] wdata_i,
   input  logic                               start_i,
   input  logic [tlb_pkg::IN_ADDR_WIDTH-1:0]  in_addr_i,
   input  logic                               rw_type_i,
   input  logic                               out_ready_i,
   output logic                               busy_o,
   output logic                               out_valid_o,
   output logic                               hit_o,
   output logic                               miss_o,
   output logic                               prot_o,
   output logic                               multi_o,
   output logic                               cache_coherent_o,
   output logic [tlb_pkg::OUT_ADDR_WIDTH-1:0] out_addr_o
);

   localparam int EA    = $clog2(N_SETS) + 1 + $clog2(N_OFFSETS);
   localparam int IDX_W = EA + $clog2(N_BANKS);

   logic                               searching;
   logic [$clog2(N_OFFSETS)-1:0]       rd_offset;
   logic                               search_done;
   logic                               result_taken;
   logic                               va_we_any;
   logic [N_BANKS-1:0]                 bank_we;
   logic [N_BANKS-1:0]                 bank_hit;
   logic [N_BANKS-1:0]                 bank_prot;
   logic [N_BANKS-1:0]                 bank_multi;
   logic [N_BANKS-1:0]                 bank_coh;
   logic [N_BANKS-1:0][EA-1:0]         bank_entry;
   logic                               hit_any;
   logic                               prot_any;
   logic                               multi_any;
   logic                               coh_sel;
   logic [IDX_W-1:0]                   pa_index;

   assign va_we_any = |bank_we;

   search_ctrl #(
      .N_OFFSETS (N_OFFSETS)
   ) i_search_ctrl (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .start_i        (start_i),
      .va_we_i        (va_we_any),
      .hit_any_i      (hit_any),
      .prot_any_i     (prot_any),
      .multi_any_i    (multi_any),
      .result_taken_i (result_taken),
      .busy_o         (busy_o),
      .searching_o    (searching),
      .rd_offset_o    (rd_offset),
      .search_done_o  (search_done)
   );

   for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
      va_bank #(
         .N_SETS    (N_SETS),
         .N_OFFSETS (N_OFFSETS),
         .N_BANKS   (N_BANKS),
         .BANK_ID   (b)
      ) i_va_bank (
         .clk_i       (clk_i),
         .rst_ni      (rst_ni),
         .cfg_we_i    (we_i),
         .cfg_addr_i  (waddr_i),
         .cfg_data_i  (wdata_i),
         .in_addr_i   (in_addr_i),
         .rw_type_i   (rw_type_i),
         .searching_i (searching),
         .rd_offset_i (rd_offset),
         .bank_we_o   (bank_we[b]),
         .hit_o       (bank_hit[b]),
         .prot_o      (bank_prot[b]),
         .multi_o     (bank_multi[b]),
         .coh_o       (bank_coh[b]),
         .hit_entry_o (bank_entry[b])
      );
   end

   hit_merge #(
      .N_SETS    (N_SETS),
      .N_OFFSETS (N_OFFSETS),
      .N_BANKS   (N_BANKS)
   ) i_hit_merge (
      .bank_hit_i   (bank_hit),
      .bank_prot_i  (bank_prot),
      .bank_multi_i (bank_multi),
      .bank_coh_i   (bank_coh),
      .bank_entry_i (bank_entry),
      .hit_any_o    (hit_any),
      .prot_any_o   (prot_any),
      .multi_any_o  (multi_any),
      .coh_sel_o    (coh_sel),
      .pa_index_o   (pa_index)
   );

   pa_lookup #(
      .N_SETS    (N_SETS),
      .N_OFFSETS (N_OFFSETS),
      .N_BANKS   (N_BANKS)
   ) i_pa_lookup (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .cfg_we_i         (we_i),
      .cfg_addr_i       (waddr_i),
      .cfg_data_i       (wdata_i),
      .in_addr_i        (in_addr_i),
      .search_done_i    (search_done),
      .hit_any_i        (hit_any),
      .prot_any_i       (prot_any),
      .multi_any_i      (multi_any),
      .coh_sel_i        (coh_sel),
      .pa_index_i       (pa_index),
      .out_ready_i      (out_ready_i),
      .result_taken_o   (result_taken),
      .out_valid_o      (out_valid_o),
      .hit_o            (hit_o),
      .miss_o           (miss_o),
      .prot_o           (prot_o),
      .multi_o          (multi_o),
      .cache_coherent_o (cache_coherent_o),
      .out_addr_o       (out_addr_o)
   );

endmodule

`default_nettype wire

//--- src/pa_lookup.sv
////////////////////////////////////////////////////////////
// PA lookup and result stage
// PA page memory, output FSM and registered result flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pa_lookup #(
   parameter int N_SETS    = tlb_pkg::DEF_N_SETS,
   parameter int N_OFFSETS = tlb_pkg::DEF_N_OFFSETS,
   parameter int N_BANKS   = tlb_pkg::DEF_N_BANKS
) (
   input  logic                                                       clk_i,
   input  logic                                                       rst_ni,
   input  logic                                                       cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_WIDTH-1:0]                         cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_WIDTH-1:0]                         cfg_data_i,
   input  logic [tlb_pkg::IN_ADDR_WIDTH-1:0]                          in_addr_i,
   input  logic                                                       search_done_i,
   input  logic                                                       hit_any_i,
   input  logic                                                       prot_any_i,
   input  logic                                                       multi_any_i,
   input  logic                                                       coh_sel_i,
   input  logic [$clog2(N_SETS)+$clog2(N_OFFSETS)+$clog2(N_BANKS):0] pa_index_i,
   input  logic                                                       out_ready_i,
   output logic                                                       result_taken_o,
   output logic                                                       out_valid_o,
   output logic                                                       hit_o,
   output logic                                                       miss_o,
   output logic                                                       prot_o,
   output logic                                                       multi_o,
   output logic                                                       cache_coherent_o,
   output logic [tlb_pkg::OUT_ADDR_WIDTH-1:0]                         out_addr_o
);

   localparam int IDX_W = $clog2(N_SETS) + 1 + $clog2(N_OFFSETS) + $clog2(N_BANKS);
   localparam int DEPTH = 2 ** IDX_W;

   tlb_pkg::out_state_t state_q;
   tlb_pkg::out_state_t state_d;
   tlb_pkg::ppn_t       pa_mem [DEPTH];
   tlb_pkg::ppn_t       ppn_q;
   logic [IDX_W-1:0]    index_q;     // Held while a PA write blocks the read
   logic [IDX_W-1:0]    pa_raddr;
   logic                pa_re;
   logic                pa_we;
   logic                clean_hit;
   logic                capture;

   assign pa_we     = cfg_we_i && cfg_addr_i[IDX_W];   // Upper half of the map
   assign clean_hit = hit_any_i && !prot_any_i && !multi_any_i;
   assign capture   = (state_q == tlb_pkg::OUT_IDLE) && search_done_i;

   ////////////////////////////////////////////////////////////
   // Output FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_d        = state_q;
      pa_re          = 1'b0;
      pa_raddr       = index_q;
      out_valid_o    = 1'b0;
      result_taken_o = 1'b0;
      case (state_q)
         tlb_pkg::OUT_IDLE: begin
            if (search_done_i) begin
               if (!clean_hit) begin
                  state_d = tlb_pkg::OUT_SEND;         // Fault or miss, nothing to read
               end else if (pa_we) begin
                  state_d = tlb_pkg::OUT_WAIT_WRITE;   // Port busy with a config write
               end else begin
                  state_d  = tlb_pkg::OUT_SEND;
                  pa_re    = 1'b1;
                  pa_raddr = pa_index_i;
               end
            end
         end
         tlb_pkg::OUT_WAIT_WRITE: begin
            if (!pa_we) begin
               state_d = tlb_pkg::OUT_SEND;
               pa_re   = 1'b1;
            end
         end
         tlb_pkg::OUT_SEND: begin
            out_valid_o = 1'b1;
            if (out_ready_i) begin
               state_d        = tlb_pkg::OUT_IDLE;
               result_taken_o = 1'b1;
            end
         end
         default: state_d = tlb_pkg::OUT_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q          <= tlb_pkg::OUT_IDLE;
         hit_o            <= 1'b0;
         miss_o           <= 1'b0;
         prot_o           <= 1'b0;
         multi_o          <= 1'b0;
         cache_coherent_o <= 1'b0;
      end else begin
         state_q <= state_d;
         if (capture) begin
            hit_o            <= hit_any_i;
            miss_o           <= !hit_any_i;
            prot_o           <= prot_any_i;
            multi_o          <= multi_any_i;
            cache_coherent_o <= clean_hit && coh_sel_i;
         end
      end
   end

   // PA page memory with its read register
   always_ff @(posedge clk_i) begin
      if (pa_we) begin
         pa_mem[cfg_addr_i[IDX_W-1:0]] <= cfg_data_i[tlb_pkg::PPN_WIDTH-1:0];
      end
      if (pa_re) begin
         ppn_q <= pa_mem[pa_raddr];
      end
      if (capture) begin
         index_q <= pa_index_i;
      end
   end

   assign out_addr_o = {ppn_q, tlb_pkg::page_off_t'(in_addr_i[tlb_pkg::PAGE_BITS-1:0])};

   // A result is either a hit of some kind or a miss, never both
   a_hit_xor_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o |-> (hit_o ^ miss_o));

endmodule

`default_nettype wire

//--- src/search_ctrl.sv
////////////////////////////////////////////////////////////
// Search control
// Walks the offsets of a set and decides when a search ends
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module search_ctrl #(
   parameter int N_OFFSETS = tlb_pkg::DEF_N_OFFSETS
) (
   input  logic                         clk_i,
   input  logic                         rst_ni,
   input  logic                         start_i,
   input  logic                         va_we_i,       // VA write pauses the walk
   input  logic                         hit_any_i,
   input  logic                         prot_any_i,
   input  logic                         multi_any_i,
   input  logic                         result_taken_i,
   output logic                         busy_o,
   output logic                         searching_o,
   output logic [$clog2(N_OFFSETS)-1:0] rd_offset_o,
   output logic                         search_done_o
);

   localparam int OFF_W = $clog2(N_OFFSETS);
   localparam logic [OFF_W-1:0] LAST_OFF = OFF_W'(N_OFFSETS - 1);

   tlb_pkg::search_state_t state_q;
   tlb_pkg::search_state_t state_d;
   logic [OFF_W-1:0]       offset_q;
   logic                   last_q;           // Last offset has been read
   logic                   result_valid_q;   // Bank results belong to this search
   logic                   stop;

   assign busy_o        = (state_q != tlb_pkg::SEARCH_IDLE);
   assign searching_o   = (state_q == tlb_pkg::SEARCH_RUN) && !va_we_i && !last_q;
   assign rd_offset_o   = offset_q;
   assign stop          = result_valid_q
                          && (hit_any_i || prot_any_i || multi_any_i || last_q);
   assign search_done_o = (state_q == tlb_pkg::SEARCH_RUN) && stop;

   ////////////////////////////////////////////////////////////
   // Search FSM
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         tlb_pkg::SEARCH_IDLE: begin
            if (start_i) begin
               state_d = tlb_pkg::SEARCH_RUN;
            end
         end
         tlb_pkg::SEARCH_RUN: begin
            if (stop) begin
               state_d = tlb_pkg::SEARCH_DONE;
            end
         end
         tlb_pkg::SEARCH_DONE: begin
            if (result_taken_i) begin   // Output handshake done
               state_d = tlb_pkg::SEARCH_IDLE;
            end
         end
         default: state_d = tlb_pkg::SEARCH_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q        <= tlb_pkg::SEARCH_IDLE;
         offset_q       <= '0;
         last_q         <= 1'b0;
         result_valid_q <= 1'b0;
      end else begin
         state_q        <= state_d;
         result_valid_q <= searching_o;
         if (state_q == tlb_pkg::SEARCH_IDLE && start_i) begin
            offset_q <= '0;   // Every search starts at offset 0
            last_q   <= 1'b0;
         end else if (searching_o) begin
            if (offset_q == LAST_OFF) begin
               last_q <= 1'b1;
            end else begin
               offset_q <= offset_q + 1'b1;
            end
         end
      end
   end

   // The walk never reads past the end of a set
   a_offset_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      searching_o |-> (rd_offset_o < N_OFFSETS));

endmodule

`default_nettype wire

//--- src/tlb_pkg.sv
////////////////////////////////////////////////////////////
// L2 TLB shared definitions
// Widths, VA entry layout, vector typedefs and FSM encodings
////////////////////////////////////////////////////////////

`default_nettype none

package tlb_pkg;

   // Address and config bus widths
   localparam int IN_ADDR_WIDTH  = 32;
   localparam int OUT_ADDR_WIDTH = 40;
   localparam int PAGE_BITS      = 12;   // 4 kB pages
   localparam int CFG_ADDR_WIDTH = 32;
   localparam int CFG_DATA_WIDTH = 64;

   localparam int VPN_WIDTH   = IN_ADDR_WIDTH - PAGE_BITS;
   localparam int PPN_WIDTH   = OUT_ADDR_WIDTH - PAGE_BITS;
   localparam int ENTRY_WIDTH = VPN_WIDTH + 4;

   // VA entry field positions
   localparam int ENTRY_VALID   = 0;
   localparam int ENTRY_RD      = 1;
   localparam int ENTRY_WR      = 2;
   localparam int ENTRY_COH     = 3;
   localparam int ENTRY_VPN_LSB = 4;

   // Default geometry, overridden from the top level
   localparam int DEF_N_SETS    = 32;
   localparam int DEF_N_OFFSETS = 4;
   localparam int DEF_N_BANKS   = 4;

   typedef logic [VPN_WIDTH-1:0]   vpn_t;
   typedef logic [PPN_WIDTH-1:0]   ppn_t;
   typedef logic [PAGE_BITS-1:0]   page_off_t;
   typedef logic [ENTRY_WIDTH-1:0] va_entry_t;

   typedef enum logic [1:0] {SEARCH_IDLE, SEARCH_RUN, SEARCH_DONE} search_state_t;
   typedef enum logic [1:0] {OUT_IDLE, OUT_WAIT_WRITE, OUT_SEND} out_state_t;

endpackage

`default_nettype wire

//--- src/va_bank.sv
////////////////////////////////////////////////////////////
// VA tag bank
// Dual-port tag array with write decode and tag compare
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module va_bank #(
   parameter int N_SETS    = tlb_pkg::DEF_N_SETS,
   parameter int N_OFFSETS = tlb_pkg::DEF_N_OFFSETS,
   parameter int N_BANKS   = tlb_pkg::DEF_N_BANKS,
   parameter int BANK_ID   = 0
) (
   input  logic                                       clk_i,
   input  logic                                       rst_ni,
   input  logic                                       cfg_we_i,
   input  logic [tlb_pkg::CFG_ADDR_WIDTH-1:0]         cfg_addr_i,
   input  logic [tlb_pkg::CFG_DATA_WIDTH-1:0]         cfg_data_i,
   input  logic [tlb_pkg::IN_ADDR_WIDTH-1:0]          in_addr_i,
   input  logic                                       rw_type_i,   // 1 = write access
   input  logic                                       searching_i,
   input  logic [$clog2(N_OFFSETS)-1:0]               rd_offset_i,
   output logic                                       bank_we_o,
   output logic                                       hit_o,
   output logic                                       prot_o,
   output logic                                       multi_o,
   output logic                                       coh_o,
   output logic [$clog2(N_SETS)+$clog2(N_OFFSETS):0]  hit_entry_o
);

   localparam int SET_W  = $clog2(N_SETS);
   localparam int BANK_W = $clog2(N_BANKS);
   localparam int EA     = SET_W + 1 + $clog2(N_OFFSETS);
   localparam int DEPTH  = 2 ** EA;

   localparam logic [tlb_pkg::CFG_ADDR_WIDTH-1:0] BANK_MASK = N_BANKS - 1;
   localparam logic [tlb_pkg::CFG_ADDR_WIDTH-1:0] BANK_SEL  = BANK_ID;

   tlb_pkg::va_entry_t tag_mem [DEPTH];
   logic [DEPTH-1:0]   valid_q;        // Valid bits, cleared on reset
   logic [EA-1:0]      waddr;
   logic [EA-1:0]      idx0;
   logic [EA-1:0]      idx1;
   logic [SET_W-1:0]   set_idx;
   tlb_pkg::vpn_t      vpn;
   tlb_pkg::va_entry_t ent0;
   tlb_pkg::va_entry_t ent1;
   tlb_pkg::va_entry_t ent_sel;
   logic               match0;
   logic               match1;

   // Word address: bank in the low bits, entry index above, PA select on top
   assign bank_we_o = cfg_we_i && !cfg_addr_i[EA+BANK_W]
                      && ((cfg_addr_i & BANK_MASK) == BANK_SEL);
   assign waddr     = cfg_addr_i[BANK_W +: EA];

   assign set_idx = in_addr_i[tlb_pkg::PAGE_BITS +: SET_W];
   assign vpn     = in_addr_i[tlb_pkg::IN_ADDR_WIDTH-1:tlb_pkg::PAGE_BITS];
   assign idx0    = {set_idx, 1'b0, rd_offset_i};
   assign idx1    = {set_idx, 1'b1, rd_offset_i};

   assign ent0    = tag_mem[idx0];
   assign ent1    = tag_mem[idx1];
   assign match0  = valid_q[idx0] && (ent0[tlb_pkg::ENTRY_VPN_LSB +: tlb_pkg::VPN_WIDTH] == vpn);
   assign match1  = valid_q[idx1] && (ent1[tlb_pkg::ENTRY_VPN_LSB +: tlb_pkg::VPN_WIDTH] == vpn);
   assign ent_sel = match0 ? ent0 : ent1;   // Port 0 wins

   always_ff @(posedge clk_i) begin
      if (bank_we_o) begin
         tag_mem[waddr] <= cfg_data_i[tlb_pkg::ENTRY_WIDTH-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         valid_q <= '0;
      end else if (bank_we_o) begin
         valid_q[waddr] <= cfg_data_i[tlb_pkg::ENTRY_VALID];
      end
   end

   // Compare results, held between search cycles
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         hit_o   <= 1'b0;
         prot_o  <= 1'b0;
         multi_o <= 1'b0;
         coh_o   <= 1'b0;
      end else if (searching_i) begin
         hit_o   <= match0 | match1;
         multi_o <= match0 & match1;
         prot_o  <= (match0 | match1)
                    && !(rw_type_i ? ent_sel[tlb_pkg::ENTRY_WR] : ent_sel[tlb_pkg::ENTRY_RD]);
         coh_o   <= ent_sel[tlb_pkg::ENTRY_COH];
      end
   end

   always_ff @(posedge clk_i) begin
      if (searching_i) begin
         hit_entry_o <= match0 ? idx0 : idx1;
      end
   end

endmodule

`default_nettype wire

//--- tb/tb_l2_tlb.sv
////////////////////////////////////////////////////////////
// L2 TLB testbench
// Table of config writes and lookups with expected results
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_l2_tlb;

   localparam int N_SETS    = tlb_pkg::DEF_N_SETS;
   localparam int N_OFFSETS = tlb_pkg::DEF_N_OFFSETS;
   localparam int N_BANKS   = tlb_pkg::DEF_N_BANKS;
   localparam int EA        = $clog2(N_SETS) + 1 + $clog2(N_OFFSETS);
   localparam int PA_SEL    = EA + $clog2(N_BANKS);   // Word address bit that selects PA memory
   localparam int TIMEOUT   = 200;

   localparam logic [1:0] ROW_VA     = 2'd0;
   localparam logic [1:0] ROW_PA     = 2'd1;
   localparam logic [1:0] ROW_LOOKUP = 2'd2;
   localparam logic [1:0] MODE_PLAIN = 2'd0;
   localparam logic [1:0] MODE_STALL = 2'd1;   // Random out_ready_i back-pressure
   localparam logic [1:0] MODE_WRITE = 2'd2;   // Config writes while the search runs

   // Entry written in the middle of a lookup, looked up later
   localparam logic [19:0] EXTRA_VPN = 20'h2001F;
   localparam logic [27:0] EXTRA_PPN = 28'h0FFFFFF;

   typedef struct packed {
      logic [1:0]  kind;
      logic [1:0]  mode;
      logic [31:0] addr;
      logic [63:0] data;
      logic        rw;
      logic        hit;
      logic        miss;
      logic        prot;
      logic        multi;
      logic        coh;
      logic [39:0] out_addr;
   } row_t;

   logic        clk_i;
   logic        rst_ni;
   logic        we_i;
   logic [31:0] waddr_i;
   logic [63:0] wdata_i;
   logic        start_i;
   logic [31:0] in_addr_i;
   logic        rw_type_i;
   logic        out_ready_i;
   logic        busy_o;
   logic        out_valid_o;
   logic        hit_o;
   logic        miss_o;
   logic        prot_o;
   logic        multi_o;
   logic        cache_coherent_o;
   logic [39:0] out_addr_o;

   row_t rows [$];
   int   seed;
   int   tests;
   int   errors;
   int   test_errors;
   logic timed_out;     // Set once a wait runs out, stops the table

   l2_tlb i_l2_tlb (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .we_i             (we_i),
      .waddr_i          (waddr_i),
      .wdata_i          (wdata_i),
      .start_i          (start_i),
      .in_addr_i        (in_addr_i),
      .rw_type_i        (rw_type_i),
      .out_ready_i      (out_ready_i),
      .busy_o           (busy_o),
      .out_valid_o      (out_valid_o),
      .hit_o            (hit_o),
      .miss_o           (miss_o),
      .prot_o           (prot_o),
      .multi_o          (multi_o),
      .cache_coherent_o (cache_coherent_o),
      .out_addr_o       (out_addr_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////
   // Address map and table helpers
   ////////////////////////////////////////////////////////////

   // Bank in the low bits, then set, port and offset
   function automatic logic [31:0] va_word_addr(input int bank, input int set, input int port,
                                                input int off);
      return 32'((((set * 2 + port) * N_OFFSETS + off) * N_BANKS) + bank);
   endfunction

   function automatic logic [31:0] pa_word_addr(input int bank, input int set, input int port,
                                                input int off);
      return va_word_addr(bank, set, port, off) | (32'd1 << PA_SEL);
   endfunction

   task automatic va_row(input int bank, input int set, input int port, input int off,
                         input logic [19:0] vpn, input logic valid, input logic rd,
                         input logic wr, input logic coh);
      row_t r;
      r      = '0;
      r.kind = ROW_VA;
      r.addr = va_word_addr(bank, set, port, off);
      r.data = 64'({vpn, coh, wr, rd, valid});
      rows.push_back(r);
   endtask

   task automatic pa_row(input int bank, input int set, input int port, input int off,
                         input logic [27:0] ppn);
      row_t r;
      r      = '0;
      r.kind = ROW_PA;
      r.addr = pa_word_addr(bank, set, port, off);
      r.data = 64'(ppn);
      rows.push_back(r);
   endtask

   task automatic lookup_row(input logic [31:0] addr, input logic rw, input logic [1:0] mode,
                             input logic hit, input logic miss, input logic prot,
                             input logic multi, input logic coh, input logic [39:0] out_addr);
      row_t r;
      r          = '0;
      r.kind     = ROW_LOOKUP;
      r.mode     = mode;
      r.addr     = addr;
      r.rw       = rw;
      r.hit      = hit;
      r.miss     = miss;
      r.prot     = prot;
      r.multi    = multi;
      r.coh      = coh;
      r.out_addr = out_addr;
      rows.push_back(r);
   endtask

   task automatic build_rows();
      va_row(0, 5, 0, 0, 20'h12345, 1, 1, 1, 1);    // Clean hit at offset 0
      pa_row(0, 5, 0, 0, 28'hABCDE01);
      va_row(2, 7, 1, 3, 20'h00A07, 1, 1, 0, 0);    // Last offset of set 7
      pa_row(2, 7, 1, 3, 28'h0123456);
      va_row(0, 7, 0, 0, 20'h00B07, 1, 1, 1, 0);    // Same set, other VPN
      va_row(1, 7, 0, 1, 20'h00A07, 0, 1, 1, 1);    // Matching VPN but not valid
      va_row(1, 11, 0, 1, 20'h5550B, 1, 1, 0, 1);   // Read-only
      pa_row(1, 11, 0, 1, 28'h555000B);
      va_row(0, 19, 0, 0, 20'h77713, 1, 1, 1, 0);   // Two banks, same offset
      va_row(3, 19, 0, 0, 20'h77713, 1, 1, 1, 0);
      va_row(2, 24, 0, 2, 20'h88818, 1, 1, 1, 0);   // Both ports of one bank
      va_row(2, 24, 1, 2, 20'h88818, 1, 1, 1, 0);
      lookup_row(32'h1234_5678, 0, MODE_PLAIN, 1, 0, 0, 0, 1, {28'hABCDE01, 12'h678});
      lookup_row(32'h00A0_7ABC, 0, MODE_PLAIN, 1, 0, 0, 0, 0, {28'h0123456, 12'hABC});
      lookup_row(32'h0BEE_F000, 0, MODE_PLAIN, 0, 1, 0, 0, 0, '0);
      lookup_row(32'h5550_B010, 1, MODE_PLAIN, 1, 0, 1, 0, 0, '0);
      lookup_row(32'h5550_B020, 0, MODE_PLAIN, 1, 0, 0, 0, 1, {28'h555000B, 12'h020});
      lookup_row(32'h7771_3444, 0, MODE_PLAIN, 1, 0, 0, 1, 0, '0);
      lookup_row(32'h8881_8555, 0, MODE_PLAIN, 1, 0, 0, 1, 0, '0);
      lookup_row(32'h1234_5FFF, 0, MODE_STALL, 1, 0, 0, 0, 1, {28'hABCDE01, 12'hFFF});
      lookup_row(32'h00A0_7123, 0, MODE_WRITE, 1, 0, 0, 0, 0, {28'h0123456, 12'h123});
      lookup_row({EXTRA_VPN, 12'h321}, 0, MODE_PLAIN, 1, 0, 0, 0, 0, {EXTRA_PPN, 12'h321});
   endtask

   ////////////////////////////////////////////////////////////
   // Checks and waits
   ////////////////////////////////////////////////////////////

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_result(input row_t r);
      check_field("out_valid_o", out_valid_o, 1'b1);
      check_field("busy_o", busy_o, 1'b1);
      check_field("hit_o", hit_o, r.hit);
      check_field("miss_o", miss_o, r.miss);
      check_field("prot_o", prot_o, r.prot);
      check_field("multi_o", multi_o, r.multi);
      if (r.hit && !r.prot && !r.multi) begin   // Address and coherence only on clean hits
         check_field("cache_coherent_o", cache_coherent_o, r.coh);
         check_field("out_addr_o", out_addr_o, r.out_addr);
      end
   endtask

   task automatic wait_for_valid();
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (out_valid_o !== 1'b1 && cycles < TIMEOUT) begin
         cycles++;
         @(negedge clk_i);
      end
      if (out_valid_o !== 1'b1) begin
         $display("Timeout at %0t: the DUT never raised out_valid_o", $time);
         test_errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_for_idle();
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (busy_o !== 1'b0 && cycles < TIMEOUT) begin
         cycles++;
         @(negedge clk_i);
      end
      if (busy_o !== 1'b0) begin
         $display("Timeout at %0t: busy_o stayed high after the result was taken", $time);
         test_errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic cfg_write(input logic [31:0] addr, input logic [63:0] data);
      @(posedge clk_i);
      we_i    <= 1'b1;
      waddr_i <= addr;
      wdata_i <= data;
      @(posedge clk_i);
      we_i    <= 1'b0;
   endtask

   task automatic run_lookup(input row_t r);
      int stall;
      @(posedge clk_i);
      in_addr_i   <= r.addr;
      rw_type_i   <= r.rw;
      start_i     <= 1'b1;
      out_ready_i <= 1'b0;
      @(posedge clk_i);
      start_i <= 1'b0;
      if (r.mode == MODE_WRITE) begin
         we_i    <= 1'b1;   // VA write to set 31 pauses the walk
         waddr_i <= va_word_addr(3, 31, 0, 0);
         wdata_i <= 64'({EXTRA_VPN, 1'b0, 1'b0, 1'b1, 1'b1});
         @(posedge clk_i);
         waddr_i <= pa_word_addr(3, 31, 0, 0);   // Held long enough to meet the PA read
         wdata_i <= 64'(EXTRA_PPN);
         repeat (6) @(posedge clk_i);
         we_i <= 1'b0;
      end
      wait_for_valid();
      if (!timed_out) begin
         check_result(r);
         if (r.mode == MODE_STALL) begin
            stall = 1 + ($unsigned($random(seed)) % 12);
            for (int i = 0; i < stall; i++) begin
               @(posedge clk_i);
               start_i <= (i == 0);   // Ignored while busy
               @(negedge clk_i);
               check_result(r);
            end
         end
         @(posedge clk_i);
         start_i     <= 1'b0;
         out_ready_i <= 1'b1;
         @(posedge clk_i);
         out_ready_i <= 1'b0;
         wait_for_idle();
         if (!timed_out && r.mode == MODE_STALL) begin
            repeat (8) begin
               @(negedge clk_i);
               check_field("out_valid_o", out_valid_o, 1'b0);
               check_field("busy_o", busy_o, 1'b0);
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_ni      = 1'b0;
      we_i        = 1'b0;
      waddr_i     = '0;
      wdata_i     = '0;
      start_i     = 1'b0;
      in_addr_i   = '0;
      rw_type_i   = 1'b0;
      out_ready_i = 1'b0;
      seed        = 32'h8105;
      tests       = 0;
      errors      = 0;
      timed_out   = 1'b0;
      build_rows();
      repeat (16) @(posedge clk_i);
      rst_ni <= 1'b1;
      for (int i = 0; i < rows.size() && !timed_out; i++) begin
         case (rows[i].kind)
            ROW_VA, ROW_PA: cfg_write(rows[i].addr, rows[i].data);
            default: begin
               test_errors = 0;
               run_lookup(rows[i]);
               tests++;
               $display("Test %0d addr 0x%08h rw %0b mode %0d: %s", tests, rows[i].addr,
                        rows[i].rw, rows[i].mode, (test_errors == 0) ? "ok" : "wrong result");
               errors += test_errors;
            end
         endcase
      end
      $display("%0d lookups run, %0d failed checks", tests, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
